// ==== logic/rv_pkg.sv ====
package rv_pkg;

  parameter int XLEN      = 64;  // Data path width
  parameter int NUM_LANES = 8;   // Byte lanes per doubleword

  // Major opcodes of the supported subset
  typedef enum logic [6:0] {
    OP     = 7'b0110011,  // Register-register ALU
    OP_IMM = 7'b0010011,  // addi only
    LUI    = 7'b0110111,
    LOAD   = 7'b0000011,  // ld, lb, lbu
    STORE  = 7'b0100011,  // sd, sb
    BRANCH = 7'b1100011,  // beq, bne
    JAL    = 7'b1101111,
    SYSTEM = 7'b1110011   // ecall only
  } opcode_e;

  // ALU operations
  typedef enum logic [2:0] {
    ADD    = 3'd0,
    SUB    = 3'd1,
    AND    = 3'd2,
    OR     = 3'd3,
    XOR    = 3'd4,
    PASS_B = 3'd5   // Operand b straight through, used by lui
  } alu_op_e;

  // Control states of the core
  typedef enum logic [2:0] {
    IDLE      = 3'd0,
    FETCH     = 3'd1,
    EXEC      = 3'd2,
    LOAD_WAIT = 3'd3,
    HALT      = 3'd4
  } core_state_e;

  // Data memory request, one EXEC cycle wide
  typedef struct packed {
    logic [XLEN-1:0] addr;     // Byte address
    logic [XLEN-1:0] wdata;    // Store data, byte stores use bits 7:0
    logic            size_dw;  // Doubleword when set, byte otherwise
    logic            sign;     // Sign-extend a byte load
    logic            wr;
    logic            rd;
    logic [3:0]      pad;      // Round up to 136 bits
  } mem_req_t;

  // Program load word
  typedef struct packed {
    logic [31:0] instr;
    logic [7:0]  addr;   // Word index into instruction memory
  } prog_word_t;

endpackage

// ==== logic/rv_regfile.sv ====
`timescale 1ns/1ps

module rv_regfile import rv_pkg::*; (
  input  logic            clk,
  input  logic            arst_n,
  input  logic [4:0]      rs1_addr,
  input  logic [4:0]      rs2_addr,
  input  logic [4:0]      rd_addr,
  input  logic            rd_we,
  input  logic [XLEN-1:0] rd_data,
  output logic [XLEN-1:0] rs1_data,
  output logic [XLEN-1:0] rs2_data,
  input  logic [4:0]      dbg_addr,
  output logic [XLEN-1:0] dbg_data
);

  logic [XLEN-1:0] regs [32];  // Entry 0 is never written

  // Read with x0 forced to zero
  function automatic logic [XLEN-1:0] read_reg(input logic [4:0] a);
    logic [XLEN-1:0] v;
    v = (a == 5'd0) ? '0 : regs[a];
    return v;
  endfunction

  always_ff @(posedge clk) begin
    if (rd_we && rd_addr != 5'd0)
      regs[rd_addr] <= rd_data;  // Single write port
  end

  always_comb rs1_data = read_reg(rs1_addr);
  always_comb rs2_data = read_reg(rs2_addr);
  always_comb dbg_data = read_reg(dbg_addr);  // Debug view through the same read path as the core

  // Core masks writes to x0 before they reach here
  a_no_x0_write: assert property (
    @(posedge clk) disable iff (!arst_n)
    !(rd_we && rd_addr == 5'd0)
  ) else $error("regfile: write enable with rd x0 unmasked");

endmodule

// ==== logic/rv_imem.sv ====
`timescale 1ns/1ps

module rv_imem import rv_pkg::*; #(
  parameter int IMEM_DEPTH = 256
) (
  input  logic            clk,
  input  logic            arst_n,
  input  logic            prog_valid,
  input  prog_word_t      prog_word,
  input  logic            core_busy,
  output logic            prog_ready,
  input  logic            fetch_en,
  input  logic [XLEN-1:0] fetch_pc,
  output logic [31:0]     instr,
  output logic            instr_valid,
  output logic            instr_error
);

  localparam int IAW = $clog2(IMEM_DEPTH);

  logic [31:0] mem [IMEM_DEPTH];
  logic        prog_fire;
  logic        pc_ok;

  assign prog_ready = !core_busy;               // Loading only while the core is parked
  assign prog_fire  = prog_valid && prog_ready;
  // Word aligned and inside the array
  assign pc_ok = (fetch_pc[1:0] == 2'b00) && (fetch_pc[XLEN-1:2] < IMEM_DEPTH);

  always_ff @(posedge clk) begin
    if (prog_fire && prog_word.addr < IMEM_DEPTH)
      mem[IAW'(prog_word.addr)] <= prog_word.instr;
    if (fetch_en)
      instr <= mem[fetch_pc[IAW+1:2]];  // Held through EXEC and LOAD_WAIT
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      instr_valid <= 1'b0;
      instr_error <= 1'b0;
    end else begin
      instr_valid <= fetch_en && pc_ok;   // One cycle after the request
      instr_error <= fetch_en && !pc_ok;
    end
  end

  // Program writes never overlap a fetch
  a_prog_idle: assert property (
    @(posedge clk) disable iff (!arst_n)
    prog_fire |-> !fetch_en
  ) else $error("imem: program write while core running");

endmodule

// ==== logic/rv_core.sv ====
`timescale 1ns/1ps

module rv_core import rv_pkg::*; #(
  parameter int IMEM_DEPTH = 256
) (
  input  logic            clk,
  input  logic            arst_n,
  input  logic            start,
  output logic            fetch_en,
  output logic [XLEN-1:0] fetch_pc,
  input  logic [31:0]     instr,
  input  logic            instr_valid,
  input  logic            instr_error,
  output logic [4:0]      rs1_addr,
  output logic [4:0]      rs2_addr,
  output logic [4:0]      rd_addr,
  output logic            rd_we,
  output logic [XLEN-1:0] rd_data,
  input  logic [XLEN-1:0] rs1_data,
  input  logic [XLEN-1:0] rs2_data,
  output mem_req_t        mem_req,
  input  logic [XLEN-1:0] load_data,
  input  logic            load_valid,
  input  logic            access_error,
  output logic            core_busy,
  output logic            done,
  output logic            error
);

  core_state_e     state;
  logic [XLEN-1:0] pc, pc_plus4, next_pc;
  opcode_e         opcode;
  alu_op_e         alu_op;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [XLEN-1:0] imm, alu_b, alu_result;
  logic            use_imm, wb_en, illegal, misaligned, taken;
  logic            is_load, is_store, is_branch, is_jal, is_ecall;
  logic            exec_ok;  // Valid, legal instruction in EXEC

  assign funct3   = instr[14:12];
  assign funct7   = instr[31:25];
  assign rs1_addr = instr[19:15];
  assign rs2_addr = instr[24:20];
  assign rd_addr  = instr[11:7];
  assign pc_plus4 = pc + 64'd4;

  // Decoder
  always_comb begin
    opcode    = opcode_e'(instr[6:0]);
    alu_op    = ADD;
    use_imm   = 1'b0;
    imm       = {{52{instr[31]}}, instr[31:20]};  // I-type by default
    wb_en     = 1'b0;
    is_load   = 1'b0;
    is_store  = 1'b0;
    is_branch = 1'b0;
    is_jal    = 1'b0;
    is_ecall  = 1'b0;
    illegal   = 1'b0;
    case (opcode)
      OP: begin
        wb_en = 1'b1;
        case ({funct7, funct3})
          10'b0000000_000: alu_op = ADD;
          10'b0100000_000: alu_op = SUB;
          10'b0000000_111: alu_op = AND;
          10'b0000000_110: alu_op = OR;
          10'b0000000_100: alu_op = XOR;
          default:         illegal = 1'b1;
        endcase
      end
      OP_IMM: begin
        wb_en   = 1'b1;
        use_imm = 1'b1;
        illegal = (funct3 != 3'b000);  // addi only
      end
      LUI: begin
        wb_en   = 1'b1;
        use_imm = 1'b1;
        alu_op  = PASS_B;
        imm     = {{32{instr[31]}}, instr[31:12], 12'b0};
      end
      LOAD: begin
        is_load = 1'b1;
        use_imm = 1'b1;                                  // rs1 + offset
        illegal = !(funct3 inside {3'b011, 3'b000, 3'b100});
      end
      STORE: begin
        is_store = 1'b1;
        use_imm  = 1'b1;
        imm      = {{52{instr[31]}}, instr[31:25], instr[11:7]};
        illegal  = !(funct3 inside {3'b011, 3'b000});
      end
      BRANCH: begin
        is_branch = 1'b1;
        alu_op    = SUB;  // Zero result means equal
        imm       = {{51{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
        illegal   = !(funct3 inside {3'b000, 3'b001});
      end
      JAL: begin
        is_jal = 1'b1;
        wb_en  = 1'b1;  // Link value
        imm    = {{43{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
      end
      SYSTEM: begin
        is_ecall = (instr == 32'h0000_0073);
        illegal  = !is_ecall;
      end
      default: illegal = 1'b1;
    endcase
  end

  // ALU
  assign alu_b = use_imm ? imm : rs2_data;
  always_comb begin
    case (alu_op)
      ADD:     alu_result = rs1_data + alu_b;
      SUB:     alu_result = rs1_data - alu_b;
      AND:     alu_result = rs1_data & alu_b;
      OR:      alu_result = rs1_data | alu_b;
      XOR:     alu_result = rs1_data ^ alu_b;
      PASS_B:  alu_result = alu_b;
      default: alu_result = rs1_data + alu_b;
    endcase
  end

  assign taken      = is_branch && ((alu_result == '0) ^ funct3[0]);  // beq / bne
  assign next_pc    = (is_jal || taken) ? pc + imm : pc_plus4;
  assign misaligned = (is_load || is_store) && funct3 == 3'b011 && alu_result[2:0] != 3'b000;
  assign exec_ok    = state == EXEC && instr_valid && !illegal && !misaligned;

  // Memory request for a single EXEC cycle
  always_comb begin
    mem_req         = '0;
    mem_req.addr    = alu_result;
    mem_req.wdata   = rs2_data;
    mem_req.size_dw = (funct3 == 3'b011);
    mem_req.sign    = (funct3 == 3'b000);  // lb
    mem_req.wr      = exec_ok && is_store;
    mem_req.rd      = exec_ok && is_load;
  end

  // Writeback, never to x0
  assign rd_data = (state == LOAD_WAIT) ? load_data : (is_jal ? pc_plus4 : alu_result);
  assign rd_we   = (rd_addr != 5'd0) &&
                   ((exec_ok && wb_en) || (state == LOAD_WAIT && load_valid && !access_error));

  assign fetch_en  = (state == FETCH);
  assign fetch_pc  = pc;
  assign core_busy = !(state == IDLE || state == HALT);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= IDLE;
      pc    <= '0;
      done  <= 1'b0;
      error <= 1'b0;
    end else begin
      case (state)
        IDLE, HALT: if (start) begin
          pc    <= '0;
          done  <= 1'b0;  // Flags clear on restart
          error <= 1'b0;
          state <= FETCH;
        end
        FETCH: state <= EXEC;
        EXEC: begin
          if (instr_error || (instr_valid && (illegal || misaligned || access_error))) begin
            error <= 1'b1;
            state <= HALT;
          end else if (instr_valid) begin
            if (is_ecall) begin
              done  <= 1'b1;
              state <= HALT;
            end else if (is_load) begin
              state <= LOAD_WAIT;
            end else begin
              pc    <= next_pc;
              state <= FETCH;
            end
          end
        end
        LOAD_WAIT: begin
          if (access_error) begin
            error <= 1'b1;
            state <= HALT;
          end else if (load_valid) begin
            pc    <= pc_plus4;
            state <= FETCH;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  a_halt_hold: assert property (
    @(posedge clk) disable iff (!arst_n)
    state == HALT && !start |=> state == HALT
  ) else $error("core: left HALT without start");

  // An in-range fetch always comes back valid from the imem
  a_fetch_valid: assert property (
    @(posedge clk) disable iff (!arst_n)
    fetch_en && fetch_pc[1:0] == 2'b00 && fetch_pc[XLEN-1:2] < IMEM_DEPTH |=> instr_valid
  ) else $error("core: in-range fetch without instr_valid");

endmodule

// ==== logic/dmem_store.sv ====
`timescale 1ns/1ps

module dmem_store import rv_pkg::*; #(
  parameter int DMEM_DEPTH = 256
) (
  input  mem_req_t                  mem_req,
  output logic [NUM_LANES-1:0]      lane_we,
  output logic [XLEN-1:0]           lane_wdata,
  output logic [$clog2(DMEM_DEPTH)-1:0] lane_addr,
  output logic                      store_error
);

  localparam int DAW = $clog2(DMEM_DEPTH);

  logic in_range;
  logic [2:0] offset;

  assign offset   = mem_req.addr[2:0];                   // Byte lane
  assign in_range = mem_req.addr[XLEN-1:3] < DMEM_DEPTH;  // Doubleword index check

  // Shared by loads and stores
  assign lane_addr = mem_req.addr[DAW+2:3];

  always_comb begin
    lane_we = '0;
    if (mem_req.wr && in_range) begin
      if (mem_req.size_dw)
        lane_we = '1;                                // Whole doubleword
      else
        lane_we = NUM_LANES'(1) << offset;           // One lane only
    end
  end

  // Byte data goes to every lane, only the enabled one takes it
  assign lane_wdata = mem_req.size_dw ? mem_req.wdata : {NUM_LANES{mem_req.wdata[7:0]}};

  assign store_error = mem_req.wr && !in_range;

endmodule

// ==== logic/dmem_lane.sv ====
`timescale 1ns/1ps

module dmem_lane #(
  parameter int DMEM_DEPTH = 256
) (
  input  logic                          clk,
  input  logic                          we,
  input  logic [$clog2(DMEM_DEPTH)-1:0] addr,
  input  logic [7:0]                    wdata,
  output logic [7:0]                    rdata
);

  logic [7:0] mem [DMEM_DEPTH];  // One byte of each doubleword

  always_ff @(posedge clk) begin
    if (we)
      mem[addr] <= wdata;
    rdata <= mem[addr];  // Registered read, old data on a same-cycle write
  end

endmodule

// ==== logic/dmem_load.sv ====
`timescale 1ns/1ps

module dmem_load import rv_pkg::*; #(
  parameter int DMEM_DEPTH = 256
) (
  input  logic            clk,
  input  logic            arst_n,
  input  mem_req_t        mem_req,
  input  logic [XLEN-1:0] lane_rdata,
  output logic [XLEN-1:0] load_data,
  output logic            load_valid,
  output logic            load_error
);

  logic [2:0] offset_q;
  logic       size_dw_q;
  logic       sign_q;
  logic       in_range;
  logic [7:0] byte_sel;

  assign in_range = mem_req.addr[XLEN-1:3] < DMEM_DEPTH;

  // Request shape, lined up with the lane read data
  always_ff @(posedge clk) begin
    offset_q  <= mem_req.addr[2:0];
    size_dw_q <= mem_req.size_dw;
    sign_q    <= mem_req.sign;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      load_valid <= 1'b0;
      load_error <= 1'b0;
    end else begin
      load_valid <= mem_req.rd && in_range;   // Pulse one cycle after the request
      load_error <= mem_req.rd && !in_range;
    end
  end

  assign byte_sel = lane_rdata[offset_q*8 +: 8];

  // lb sign-extends, lbu zero-extends
  assign load_data = size_dw_q ? lane_rdata
                               : {{(XLEN-8){sign_q & byte_sel[7]}}, byte_sel};

endmodule

// ==== logic/rv_top.sv ====
`timescale 1ns/1ps

module rv_top import rv_pkg::*; #(
  parameter int IMEM_DEPTH = 256,
  parameter int DMEM_DEPTH = 256
) (
  input  logic            clk,
  input  logic            arst_n,
  input  logic            prog_valid,
  input  prog_word_t      prog_word,
  output logic            prog_ready,
  input  logic            start,
  input  logic [4:0]      dbg_addr,
  output logic [XLEN-1:0] dbg_data,
  output logic            done,
  output logic            error
);

  logic                          fetch_en, instr_valid, instr_error, core_busy;
  logic [XLEN-1:0]               fetch_pc;
  logic [31:0]                   instr;
  logic [4:0]                    rs1_addr, rs2_addr, rd_addr;
  logic                          rd_we;
  logic [XLEN-1:0]               rd_data, rs1_data, rs2_data;
  mem_req_t                      mem_req;
  logic [NUM_LANES-1:0]          lane_we;
  logic [XLEN-1:0]               lane_wdata, lane_rdata, load_data;
  logic [$clog2(DMEM_DEPTH)-1:0] lane_addr;
  logic                          load_valid, load_error, store_error;

  rv_core #(.IMEM_DEPTH(IMEM_DEPTH)) core0 (
    .clk, .arst_n, .start,
    .fetch_en, .fetch_pc, .instr, .instr_valid, .instr_error,
    .rs1_addr, .rs2_addr, .rd_addr, .rd_we, .rd_data, .rs1_data, .rs2_data,
    .mem_req, .load_data, .load_valid,
    .access_error(store_error | load_error),  // Either side halts the core
    .core_busy, .done, .error
  );

  rv_regfile regs0 (
    .clk, .arst_n, .rs1_addr, .rs2_addr, .rd_addr, .rd_we, .rd_data,
    .rs1_data, .rs2_data, .dbg_addr, .dbg_data
  );

  rv_imem #(.IMEM_DEPTH(IMEM_DEPTH)) imem0 (
    .clk, .arst_n, .prog_valid, .prog_word, .core_busy, .prog_ready,
    .fetch_en, .fetch_pc, .instr, .instr_valid, .instr_error
  );

  dmem_store #(.DMEM_DEPTH(DMEM_DEPTH)) dstore0 (
    .mem_req, .lane_we, .lane_wdata, .lane_addr, .store_error
  );

  // Byte lane RAMs, all on the same doubleword index
  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    dmem_lane #(.DMEM_DEPTH(DMEM_DEPTH)) lane (
      .clk, .we(lane_we[i]), .addr(lane_addr),
      .wdata(lane_wdata[8*i +: 8]), .rdata(lane_rdata[8*i +: 8])
    );
  end

  dmem_load #(.DMEM_DEPTH(DMEM_DEPTH)) dload0 (
    .clk, .arst_n, .mem_req, .lane_rdata, .load_data, .load_valid, .load_error
  );

endmodule

// ==== verif/tb_top.sv ====
`timescale 1ns/1ps

module tb_top import rv_pkg::*; ();

  localparam int NUM_TESTS = 16;
  localparam int PROLOGUE  = 39;                      // 31 addi then 8 sd
  localparam int BODY      = 20;
  localparam int MAX_INSTR = PROLOGUE + BODY + 1;     // Last word is ecall
  localparam int WATCHDOG_CYCLES = NUM_TESTS * MAX_INSTR * 3 + NUM_TESTS * (MAX_INSTR + 40) + 20;

  logic            clk;
  logic            arst_n;
  logic            prog_valid;
  prog_word_t      prog_word;
  logic            prog_ready;
  logic            start;
  logic [4:0]      dbg_addr;
  logic [XLEN-1:0] dbg_data;
  logic            done;
  logic            error;

  logic [31:0] prog [MAX_INSTR];
  logic [63:0] model_regs [32];   // Reference register file
  logic [7:0]  model_mem [2048];  // Reference byte memory
  logic        exp_done;
  logic        exp_error;
  int          checks;
  int          errors;
  int          tests_failed;
  string       kind_names [4] = '{"alu", "memory", "control", "halting"};

  rv_top #(.IMEM_DEPTH(256), .DMEM_DEPTH(256)) dut0 (
    .clk, .arst_n, .prog_valid, .prog_word, .prog_ready, .start,
    .dbg_addr, .dbg_data, .done, .error
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %s: got %h expected %h", name, got, exp);
    end
  endtask

  // Instruction encoders
  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [2:0] f3);
    return {imm[11:5], rs2, 5'd0, f3, imm[4:0], 7'h23};  // Base is always x0
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  function automatic logic [31:0] rand_alu();
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] w;
    rd  = 5'($urandom_range(0, 31));  // x0 included so its writes must vanish
    rs1 = 5'($urandom_range(0, 31));
    rs2 = 5'($urandom_range(0, 31));
    case ($urandom_range(0, 6))
      0:       w = r_type(7'h00, rs2, rs1, 3'h0, rd);         // add
      1:       w = r_type(7'h20, rs2, rs1, 3'h0, rd);         // sub
      2:       w = r_type(7'h00, rs2, rs1, 3'h7, rd);         // and
      3:       w = r_type(7'h00, rs2, rs1, 3'h6, rd);         // or
      4:       w = r_type(7'h00, rs2, rs1, 3'h4, rd);         // xor
      5:       w = i_type(12'($urandom), rs1, 3'h0, rd, 7'h13);  // addi
      default: w = {20'($urandom), rd, 7'h37};                 // lui
    endcase
    return w;
  endfunction

  // Loads and stores stay inside the first 64 bytes that the prologue sets up
  function automatic logic [31:0] rand_mem();
    logic [4:0]  rd;
    logic [4:0]  rs2;
    logic [31:0] w;
    rd  = 5'($urandom_range(0, 31));
    rs2 = 5'($urandom_range(0, 31));
    case ($urandom_range(0, 4))
      0:       w = s_type(12'(8 * $urandom_range(0, 7)), rs2, 3'h3);                // sd
      1:       w = s_type(12'($urandom_range(0, 63)), rs2, 3'h0);                   // sb
      2:       w = i_type(12'(8 * $urandom_range(0, 7)), 5'd0, 3'h3, rd, 7'h03);    // ld
      3:       w = i_type(12'($urandom_range(0, 63)), 5'd0, 3'h0, rd, 7'h03);       // lb
      default: w = i_type(12'($urandom_range(0, 63)), 5'd0, 3'h4, rd, 7'h03);       // lbu
    endcase
    return w;
  endfunction

  // Forward targets only and never past the final ecall
  function automatic logic [31:0] rand_ctrl(input int p);
    int          k;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] w;
    k   = $urandom_range(1, MAX_INSTR - 1 - p);
    rs1 = 5'($urandom_range(1, 4));
    rs2 = ($urandom_range(0, 1) == 1) ? rs1 : 5'($urandom_range(1, 4));  // Equal half the time
    case ($urandom_range(0, 2))
      0:       w = b_type(13'(k * 4), rs2, rs1, 3'h0);                   // beq
      1:       w = b_type(13'(k * 4), rs2, rs1, 3'h1);                   // bne
      default: w = j_type(21'(k * 4), 5'($urandom_range(0, 31)));        // jal
    endcase
    return w;
  endfunction

  function automatic logic [31:0] rand_fault();
    logic [31:0] w;
    case ($urandom_range(0, 2))
      0:       w = 32'hffff_ffff;                                  // Unknown opcode
      1:       w = r_type(7'h01, 5'd3, 5'd2, 3'h0, 5'd1);          // mul is outside the subset
      default: w = i_type(12'(8 * $urandom_range(0, 6) + $urandom_range(1, 7)),
                          5'd0, 3'h3, 5'd1, 7'h03);                // Misaligned ld
    endcase
    return w;
  endfunction

  task automatic build_program(input int kind);
    int fault_pos;
    for (int r = 1; r < 32; r++)
      prog[r-1] = i_type(12'($urandom), 5'd0, 3'h0, 5'(r), 7'h13);  // Every register defined
    for (int d = 0; d < 8; d++)
      prog[31+d] = s_type(12'(8 * d), 5'($urandom_range(1, 31)), 3'h3);  // Memory window defined
    for (int p = PROLOGUE; p < MAX_INSTR - 1; p++) begin
      case (kind)
        1:       prog[p] = ($urandom_range(0, 1) == 1) ? rand_mem() : rand_alu();
        2:       prog[p] = ($urandom_range(0, 9) < 3) ? rand_ctrl(p) : rand_alu();
        default: prog[p] = rand_alu();
      endcase
    end
    fault_pos = $urandom_range(PROLOGUE, MAX_INSTR - 2);
    if (kind == 3)
      prog[fault_pos] = rand_fault();
    prog[MAX_INSTR-1] = 32'h0000_0073;  // ecall
  endtask

  // Instruction-set model that runs until ecall or a fault
  task automatic run_model();
    logic [63:0] pc, npc, a, b, res, addr, iimm, simm, bimm, jimm;
    logic [31:0] w;
    logic [4:0]  rd;
    logic [2:0]  f3;
    logic        wr;
    int          steps;
    int          k;
    pc        = '0;
    steps     = 0;
    exp_done  = 1'b0;
    exp_error = 1'b0;
    while (!exp_done && !exp_error && steps < 2 * MAX_INSTR) begin
      w    = prog[int'(pc[31:2])];
      rd   = w[11:7];
      f3   = w[14:12];
      a    = model_regs[w[19:15]];
      b    = model_regs[w[24:20]];
      iimm = 64'($signed(w[31:20]));
      simm = 64'($signed({w[31:25], w[11:7]}));
      bimm = 64'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
      jimm = 64'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
      npc  = pc + 64'd4;
      wr   = 1'b0;
      res  = '0;
      case (w[6:0])
        7'h33: begin
          wr = 1'b1;
          case ({w[31:25], f3})
            10'h000: res = a + b;
            10'h100: res = a - b;
            10'h007: res = a & b;
            10'h006: res = a | b;
            10'h004: res = a ^ b;
            default: exp_error = 1'b1;
          endcase
        end
        7'h13: begin
          wr = 1'b1;
          if (f3 == 3'h0)
            res = a + iimm;
          else
            exp_error = 1'b1;
        end
        7'h37: begin
          wr  = 1'b1;
          res = 64'($signed({w[31:12], 12'h000}));  // 32-bit result sign-extended
        end
        7'h03: begin
          wr   = 1'b1;
          addr = a + iimm;
          if (f3 == 3'h3 && addr[2:0] != 3'd0)
            exp_error = 1'b1;  // Misaligned doubleword
          else if (f3 == 3'h3)
            for (k = 7; k >= 0; k--)
              res = {res[55:0], model_mem[addr[10:0] + k]};  // Little endian
          else if (f3 == 3'h0)
            res = {{56{model_mem[addr[10:0]][7]}}, model_mem[addr[10:0]]};
          else if (f3 == 3'h4)
            res = {56'd0, model_mem[addr[10:0]]};
          else
            exp_error = 1'b1;
        end
        7'h23: begin
          addr = a + simm;
          if (f3 == 3'h3 && addr[2:0] != 3'd0)
            exp_error = 1'b1;
          else if (f3 == 3'h3)
            for (k = 0; k < 8; k++)
              model_mem[addr[10:0] + k] = b[8*k +: 8];
          else if (f3 == 3'h0)
            model_mem[addr[10:0]] = b[7:0];
          else
            exp_error = 1'b1;
        end
        7'h63: begin
          if (f3 == 3'h0 && a == b)
            npc = pc + bimm;
          else if (f3 == 3'h1 && a != b)
            npc = pc + bimm;
          else if (f3 > 3'h1)
            exp_error = 1'b1;
        end
        7'h6f: begin
          wr  = 1'b1;
          res = pc + 64'd4;  // Link value
          npc = pc + jimm;
        end
        7'h73: begin
          if (w == 32'h0000_0073)
            exp_done = 1'b1;
          else
            exp_error = 1'b1;
        end
        default: exp_error = 1'b1;
      endcase
      if (wr && !exp_error && rd != 5'd0)
        model_regs[rd] = res;
      pc = npc;
      steps++;
    end
  endtask

  task automatic load_program();
    for (int i = 0; i < MAX_INSTR; i++) begin
      @(posedge clk);
      prog_valid <= 1'b1;
      prog_word  <= '{instr: prog[i], addr: 8'(i)};
      @(negedge clk);
      check_value("prog_ready", prog_ready, 1);  // Word accepted on the next edge
    end
    @(posedge clk);
    prog_valid <= 1'b0;
  endtask

  task automatic check_regs();
    for (int r = 0; r < 32; r++) begin
      @(posedge clk);
      dbg_addr <= 5'(r);
      @(negedge clk);
      check_value($sformatf("x%0d", r), dbg_data, model_regs[r]);
    end
  endtask

  task automatic run_test(input int t);
    int kind;
    int err_before;
    kind       = t % 4;
    err_before = errors;
    build_program(kind);
    run_model();
    load_program();
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    @(negedge clk);
    check_value("prog_ready", prog_ready, 0);  // Core now running
    while (!(done || error))
      @(negedge clk);
    check_value("prog_ready", prog_ready, 1);
    check_value("done", done, exp_done);
    check_value("error", error, exp_error);
    check_regs();
    if (errors != err_before)
      tests_failed++;
    $display("test %0d %s: %s", t, kind_names[kind], (errors == err_before) ? "ok" : "mismatch");
  endtask

  initial begin
    void'($urandom(19573));
    arst_n       = 1'b0;
    prog_valid   = 1'b0;
    prog_word    = '0;
    start        = 1'b0;
    dbg_addr     = '0;
    checks       = 0;
    errors       = 0;
    tests_failed = 0;
    for (int r = 0; r < 32; r++)
      model_regs[r] = '0;
    for (int m = 0; m < 2048; m++)
      model_mem[m] = '0;
    repeat (3) @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    check_value("prog_ready", prog_ready, 1);  // Idle after reset
    check_value("done", done, 0);
    check_value("error", error, 0);
    for (int t = 0; t < NUM_TESTS; t++)
      run_test(t);
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             NUM_TESTS, tests_failed, checks, errors);
    if (errors == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

  // Watchdog
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

// ==== list.f ====
logic/rv_pkg.sv
logic/rv_regfile.sv
logic/rv_imem.sv
logic/rv_core.sv
logic/dmem_store.sv
logic/dmem_lane.sv
logic/dmem_load.sv
logic/rv_top.sv
verif/tb_top.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f list.f \
  -o tb_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log
grep -q "Simulation FAILED" sim.log && exit 1
grep -q "Simulation PASSED" sim.log || exit 1
exit 0
